// ==== list.f ====
+incdir+design
design/axi_burst_pkg.sv
design/xfer_pkg.sv
design/xfer_setup.sv
design/stream_fifo.sv
design/wdata_channel.sv
design/awaddr_channel.sv
design/bresp_tracker.sv
design/axi_write_master.sv
dv/axi_write_master_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module axi_write_master_tb \
  -f list.f -o axi_write_master_sim \
  && { ./obj_dir/axi_write_master_sim > sim.log 2>&1 || true; } \
  && cat sim.log \
  && grep -q "All tests passed" sim.log \
  || { echo "Simulation did not pass"; exit 1; }

// ==== dv/axi_write_master_tb.sv ====
// AXI write master testbench
`timescale 1ns/1ps
`include "write_master_config.svh"

module axi_write_master_tb
  import axi_burst_pkg::*, xfer_pkg::*;
();

  localparam int MAX_OUT     = `WM_MAX_OUTSTANDING;
  localparam int FIFO_DEPTH  = `WM_FIFO_DEPTH;
  localparam int HOLD_CYCLES = 300;
  localparam int N_REQ       = 7;

  // One request and its hand-derived results
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] bytes;
    logic        hold;
    logic [7:0]  bursts;
    logic [3:0]  last_strb;
  } req_row_t;

  // Offset, byte count, hold responses, burst count, last-beat strobe
  localparam req_row_t REQ_TABLE [N_REQ] = '{
    '{32'h0000_0000, 32'd1,     1'b0, 8'd1,  4'b0001},
    '{32'h0000_1234, 32'd4,     1'b0, 8'd1,  4'b1111},
    '{32'h0001_0010, 32'd7,     1'b0, 8'd1,  4'b0111},
    '{32'h0000_0400, 32'd1024,  1'b0, 8'd1,  4'b1111},
    '{32'h0002_07ff, 32'd2500,  1'b0, 8'd3,  4'b1111},
    '{32'h0010_0123, 32'd40960, 1'b1, 8'd40, 4'b1111},
    '{32'h0000_0c01, 32'd1022,  1'b0, 8'd1,  4'b0011}
  };

  logic       aclk;
  logic       areset;
  logic       ctrl_start;
  axi_addr_t  ctrl_addr_offset;
  xfer_size_u ctrl_xfer_size_in_bytes;
  logic       ctrl_done;
  logic       s_axis_tvalid;
  axi_data_t  s_axis_tdata;
  logic       s_axis_tready;
  logic       m_axi_awvalid;
  logic       m_axi_awready;
  axi_addr_t  m_axi_awaddr;
  burst_len_t m_axi_awlen;
  logic       m_axi_wvalid;
  logic       m_axi_wready;
  axi_data_t  m_axi_wdata;
  axi_strb_t  m_axi_wstrb;
  logic       m_axi_wlast;
  logic       m_axi_bvalid;
  logic       m_axi_bready;

  // Current request, set between clock edges
  req_row_t  cur;
  int        exp_words;
  int        exp_last_len;
  axi_addr_t exp_base;

  // Slave and stream bookkeeping
  int unsigned lcg_state = 73;
  int          aw_idx;
  int          w_beat;
  int          w_burst;
  int          beat_in_burst;
  int          b_idx;
  int          peak_out;
  int          hold_timer;
  int          b_wait;
  int          done_cnt;
  longint      send_cnt;
  longint      recv_cnt;
  longint      stream_total;
  logic        done_due;
  logic        hold_active;
  logic        stream_taken;
  logic        b_taken;

  axi_write_master axi_write_master_i (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .ctrl_done               (ctrl_done),
    .s_axis_tvalid           (s_axis_tvalid),
    .s_axis_tdata            (s_axis_tdata),
    .s_axis_tready           (s_axis_tready),
    .m_axi_awvalid           (m_axi_awvalid),
    .m_axi_awready           (m_axi_awready),
    .m_axi_awaddr            (m_axi_awaddr),
    .m_axi_awlen             (m_axi_awlen),
    .m_axi_wvalid            (m_axi_wvalid),
    .m_axi_wready            (m_axi_wready),
    .m_axi_wdata             (m_axi_wdata),
    .m_axi_wstrb             (m_axi_wstrb),
    .m_axi_wlast             (m_axi_wlast),
    .m_axi_bvalid            (m_axi_bvalid),
    .m_axi_bready            (m_axi_bready)
  );

  ////////////////////////////////
  // Helpers
  ////////////////////////////////

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Byte count rounded up to whole beats
  function automatic int words_of(input logic [31:0] bytes);
    return int'((bytes + DW_BYTES - 1) / DW_BYTES);
  endfunction

  // Full bursts carry 256 beats, the last one the rest
  function automatic burst_len_t burst_len_of(input int idx);
    if (idx == int'(cur.bursts) - 1) begin
      return burst_len_t'(exp_last_len);
    end
    return burst_len_t'(BURST_BEATS - 1);
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "Stopped at first error");
  endtask

  ////////////////////////////////
  // Monitor, sampled on the rising edge
  ////////////////////////////////

  task automatic monitor_cycle();
    logic      exp_last;
    axi_strb_t exp_strb;
    int        out_now;
    longint    fill;
    // Words held in the FIFO before this edge
    fill = send_cnt - recv_cnt - longint'(stream_taken);
    assert (s_axis_tready == (fill < FIFO_DEPTH))
      else report_error($sformatf("s_axis_tready is %0b with %0d words buffered",
                                  s_axis_tready, fill));
    // Done only in the cycle after the final response
    assert (ctrl_done == done_due)
      else report_error($sformatf("ctrl_done is %0b, expected %0b", ctrl_done, done_due));
    if (ctrl_done) begin
      done_cnt++;
    end
    done_due = 1'b0;
    // New request, previous one fully retired
    if (ctrl_start) begin
      aw_idx        = 0;
      w_beat        = 0;
      w_burst       = 0;
      beat_in_burst = 0;
      b_idx         = 0;
      peak_out      = 0;
      hold_timer    = 0;
      hold_active   = cur.hold;
      stream_total  = stream_total + exp_words;
    end
    if (m_axi_awvalid && m_axi_awready) begin
      assert (aw_idx < int'(cur.bursts))
        else report_error($sformatf("extra address %h", m_axi_awaddr));
      assert (m_axi_awaddr == exp_base + axi_addr_t'(aw_idx * BURST_BYTES))
        else report_error($sformatf("burst %0d awaddr %h", aw_idx, m_axi_awaddr));
      assert (m_axi_awlen == burst_len_of(aw_idx))
        else report_error($sformatf("burst %0d awlen %0d", aw_idx, m_axi_awlen));
      aw_idx++;
    end
    if (m_axi_wvalid && m_axi_wready) begin
      exp_last = (burst_len_t'(beat_in_burst) == burst_len_of(w_burst));
      exp_strb = (w_beat == exp_words - 1) ? axi_strb_t'(cur.last_strb) : '1;
      assert (w_beat < exp_words)
        else report_error($sformatf("extra data beat %h", m_axi_wdata));
      assert (m_axi_wdata == axi_data_t'(recv_cnt))
        else report_error($sformatf("wdata %h, expected %h", m_axi_wdata, recv_cnt));
      assert (m_axi_wlast == exp_last)
        else report_error($sformatf("beat %0d wlast is %0b", w_beat, m_axi_wlast));
      assert (m_axi_wstrb == exp_strb)
        else report_error($sformatf("beat %0d wstrb %b, expected %b",
                                    w_beat, m_axi_wstrb, exp_strb));
      recv_cnt++;
      w_beat++;
      if (exp_last) begin
        w_burst++;
        beat_in_burst = 0;
      end else begin
        beat_in_burst++;
      end
    end
    if (b_taken) begin
      b_idx++;
      b_wait   = int'(next_random() % 8);
      done_due = (b_idx == int'(cur.bursts));
    end
    // Addresses accepted ahead of their responses
    out_now = aw_idx - b_idx;
    assert (out_now <= MAX_OUT)
      else report_error($sformatf("%0d addresses outstanding", out_now));
    if (out_now > peak_out) begin
      peak_out = out_now;
    end
    if (hold_active && out_now == MAX_OUT) begin
      hold_timer++;
    end
    if (hold_timer > HOLD_CYCLES) begin
      hold_active = 1'b0;
    end
  endtask

  ////////////////////////////////
  // Slave and stream drive, just after the edge
  ////////////////////////////////

  task automatic drive_bus();
    m_axi_awready = (next_random() % 4) != 0;
    m_axi_wready  = (next_random() % 4) != 0;
    // Stream word stays until taken
    if (!s_axis_tvalid || stream_taken) begin
      s_axis_tvalid = (send_cnt < stream_total) && ((next_random() % 5) != 0);
      s_axis_tdata  = axi_data_t'(send_cnt);
    end
    if (b_taken) begin
      m_axi_bvalid = 1'b0;
    end
    // A response needs both its address and its wlast
    if (!m_axi_bvalid && !hold_active && b_idx < aw_idx && b_idx < w_burst) begin
      if (b_wait == 0) begin
        m_axi_bvalid = 1'b1;
      end else begin
        b_wait--;
      end
    end
  endtask

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  initial begin : bus_model
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    {aw_idx, w_beat, w_burst, beat_in_burst, b_idx} = '0;
    {peak_out, hold_timer, b_wait, done_cnt} = '0;
    {send_cnt, recv_cnt, stream_total} = '0;
    done_due    = 1'b0;
    hold_active = 1'b0;
    forever begin
      @(posedge aclk);
      stream_taken = s_axis_tvalid && s_axis_tready;
      b_taken      = m_axi_bvalid && m_axi_bready;
      if (stream_taken) begin
        send_cnt++;
      end
      if (!areset) begin
        monitor_cycle();
      end
      #1;
      drive_bus();
    end
  end

  ////////////////////////////////
  // Request sequence
  ////////////////////////////////

  initial begin : main_sequence
    areset                        = 1'b1;
    ctrl_start                    = 1'b0;
    ctrl_addr_offset              = '0;
    ctrl_xfer_size_in_bytes.bytes = '0;
    repeat (4) @(posedge aclk);
    #1 areset = 1'b0;
    @(negedge aclk);
    assert (!m_axi_awvalid && !m_axi_wvalid && !ctrl_done && m_axi_bready)
      else report_error("outputs not at their idle values after reset");
    for (int r = 0; r < N_REQ; r++) begin
      @(negedge aclk);
      cur          = REQ_TABLE[r];
      exp_words    = words_of(cur.bytes);
      exp_last_len = exp_words - BURST_BEATS * (int'(cur.bursts) - 1) - 1;
      // Offset cleared down to the burst boundary
      exp_base     = axi_addr_t'((cur.addr / BURST_BYTES) * BURST_BYTES);
      @(posedge aclk);
      #1;
      ctrl_start                    = 1'b1;
      ctrl_addr_offset              = cur.addr;
      ctrl_xfer_size_in_bytes.bytes = cur.bytes;
      @(posedge aclk);
      #1 ctrl_start = 1'b0;
      while (done_cnt <= r) @(negedge aclk);
      assert (aw_idx == int'(cur.bursts) && b_idx == int'(cur.bursts))
        else report_error($sformatf("request %0d saw %0d addresses and %0d responses",
                                    r, aw_idx, b_idx));
      assert (w_beat == exp_words && recv_cnt == stream_total)
        else report_error($sformatf("request %0d wrote %0d of %0d beats",
                                    r, w_beat, exp_words));
      if (cur.hold) begin
        assert (peak_out == MAX_OUT)
          else report_error($sformatf("outstanding peaked at %0d", peak_out));
      end
    end
    $display("%0d requests checked", N_REQ);
    $display("All tests passed");
    $finish;
  end

  // Bound from the total beat count of the table
  initial begin : watchdog
    longint limit;
    limit = 1000;
    for (int r = 0; r < N_REQ; r++) begin
      limit = limit + 40 * words_of(REQ_TABLE[r].bytes);
    end
    repeat (limit) @(posedge aclk);
    $display("Timeout: the requests did not complete within %0d cycles", limit);
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== design/axi_write_master.sv ====
// AXI4 write master top
`timescale 1ns/1ps

module axi_write_master
  import axi_burst_pkg::*, xfer_pkg::*;
(
  input  logic       aclk,
  input  logic       areset,
  // Control
  input  logic       ctrl_start,
  input  axi_addr_t  ctrl_addr_offset,
  input  xfer_size_u ctrl_xfer_size_in_bytes,
  output logic       ctrl_done,
  // Stream input
  input  logic       s_axis_tvalid,
  input  axi_data_t  s_axis_tdata,
  output logic       s_axis_tready,
  // AXI write address
  output logic       m_axi_awvalid,
  input  logic       m_axi_awready,
  output axi_addr_t  m_axi_awaddr,
  output burst_len_t m_axi_awlen,
  // AXI write data
  output logic       m_axi_wvalid,
  input  logic       m_axi_wready,
  output axi_data_t  m_axi_wdata,
  output axi_strb_t  m_axi_wstrb,
  output logic       m_axi_wlast,
  // AXI write response
  input  logic       m_axi_bvalid,
  output logic       m_axi_bready
);

  logic         start;
  axi_addr_t    addr_base;
  burst_count_t burst_count;
  burst_len_t   final_len;
  axi_strb_t    final_strb;
  logic         single_burst;
  logic         fifo_full;
  logic         fifo_wr_en;
  logic         fifo_valid;
  axi_data_t    fifo_data;
  logic         fifo_pop;
  logic         first_beat_pulse;
  logic         aw_done_xfer;
  logic         aw_stall;

  // Stream handshake on the FIFO write side
  assign s_axis_tready = ~fifo_full;
  assign fifo_wr_en    = s_axis_tvalid & s_axis_tready;

  xfer_setup xfer_setup_i (
    .aclk                    (aclk),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .start                   (start),
    .addr_base               (addr_base),
    .burst_count             (burst_count),
    .final_len               (final_len),
    .final_strb              (final_strb),
    .single_burst            (single_burst)
  );

  stream_fifo stream_fifo_i (
    .aclk     (aclk),
    .areset   (areset),
    .wr_en    (fifo_wr_en),
    .wr_data  (s_axis_tdata),
    .full     (fifo_full),
    .rd_en    (fifo_pop),
    .rd_data  (fifo_data),
    .rd_valid (fifo_valid)
  );

  wdata_channel wdata_channel_i (
    .aclk             (aclk),
    .areset           (areset),
    .start            (start),
    .burst_count      (burst_count),
    .final_len        (final_len),
    .final_strb       (final_strb),
    .single_burst     (single_burst),
    .fifo_valid       (fifo_valid),
    .fifo_data        (fifo_data),
    .fifo_pop         (fifo_pop),
    .m_axi_wvalid     (m_axi_wvalid),
    .m_axi_wready     (m_axi_wready),
    .m_axi_wdata      (m_axi_wdata),
    .m_axi_wstrb      (m_axi_wstrb),
    .m_axi_wlast      (m_axi_wlast),
    .first_beat_pulse (first_beat_pulse)
  );

  awaddr_channel awaddr_channel_i (
    .aclk             (aclk),
    .areset           (areset),
    .start            (start),
    .addr_base        (addr_base),
    .burst_count      (burst_count),
    .final_len        (final_len),
    .single_burst     (single_burst),
    .first_beat_pulse (first_beat_pulse),
    .aw_stall         (aw_stall),
    .m_axi_awvalid    (m_axi_awvalid),
    .m_axi_awready    (m_axi_awready),
    .m_axi_awaddr     (m_axi_awaddr),
    .m_axi_awlen      (m_axi_awlen),
    .aw_done_xfer     (aw_done_xfer)
  );

  bresp_tracker bresp_tracker_i (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .burst_count  (burst_count),
    .aw_done_xfer (aw_done_xfer),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .aw_stall     (aw_stall),
    .ctrl_done    (ctrl_done)
  );

endmodule

// ==== design/bresp_tracker.sv ====
// Write response tracking
`timescale 1ns/1ps
`include "write_master_config.svh"

module bresp_tracker
  import axi_burst_pkg::*, xfer_pkg::*;
(
  input  logic         aclk,
  input  logic         areset,
  input  logic         start,
  input  burst_count_t burst_count,
  input  logic         aw_done_xfer,
  input  logic         m_axi_bvalid,
  output logic         m_axi_bready,
  output logic         aw_stall,
  output logic         ctrl_done
);

  localparam outstanding_t MAX_OUT = outstanding_t'(`WM_MAX_OUTSTANDING);

  logic         bxfer;
  burst_count_t resp_left;
  outstanding_t vacancy;

  // Responses always taken, code not checked
  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;
  assign aw_stall     = (vacancy == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      resp_left <= '0;
      vacancy   <= MAX_OUT;
      ctrl_done <= 1'b0;
    end else begin
      if (start) begin
        resp_left <= burst_count;
      end else if (bxfer) begin
        resp_left <= resp_left - 1'b1;
      end
      // Address out takes a slot, response gives it back
      if (aw_done_xfer && !bxfer) begin
        vacancy <= vacancy - 1'b1;
      end else if (bxfer && !aw_done_xfer) begin
        vacancy <= vacancy + 1'b1;
      end
      ctrl_done <= bxfer && (resp_left == '0);
    end
  end

  // Every response matches an earlier address handshake
  resp_has_aw: assert property (@(posedge aclk) disable iff (areset)
    m_axi_bvalid |-> (vacancy < MAX_OUT));

endmodule

// ==== design/awaddr_channel.sv ====
// Write address channel
`timescale 1ns/1ps

module awaddr_channel
  import axi_burst_pkg::*, xfer_pkg::*;
(
  input  logic         aclk,
  input  logic         areset,
  input  logic         start,
  input  axi_addr_t    addr_base,
  input  burst_count_t burst_count,
  input  burst_len_t   final_len,
  input  logic         single_burst,
  input  logic         first_beat_pulse,
  input  logic         aw_stall,
  output logic         m_axi_awvalid,
  input  logic         m_axi_awready,
  output axi_addr_t    m_axi_awaddr,
  output burst_len_t   m_axi_awlen,
  output logic         aw_done_xfer
);

  localparam burst_len_t FULL_LEN = burst_len_t'(BURST_BEATS - 1);

  logic         awvalid_r;
  logic         awxfer;
  axi_addr_t    addr_r;
  burst_len_t   awlen_r;
  burst_count_t bursts_left;
  // First beats seen but not yet given an address
  burst_count_t pending;

  assign m_axi_awvalid = awvalid_r;
  assign m_axi_awaddr  = addr_r;
  assign m_axi_awlen   = awlen_r;
  assign awxfer        = awvalid_r & m_axi_awready;
  assign aw_done_xfer  = awxfer;

  ////////////////////////////////
  // Pending addresses
  ////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      pending <= '0;
    end else if (first_beat_pulse && !awxfer) begin
      pending <= pending + 1'b1;
    end else if (awxfer && !first_beat_pulse) begin
      pending <= pending - 1'b1;
    end
  end

  // Valid rises on demand and drops only on acceptance
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid_r <= 1'b0;
    end else if (!awvalid_r) begin
      awvalid_r <= (pending != '0) && !aw_stall;
    end else if (m_axi_awready) begin
      awvalid_r <= 1'b0;
    end
  end

  ////////////////////////////////
  // Address and length
  ////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (start) begin
      bursts_left <= burst_count;
    end else if (awxfer) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  // Next burst address and length are ready before valid rises
  always_ff @(posedge aclk) begin
    if (start) begin
      addr_r  <= addr_base;
      awlen_r <= single_burst ? final_len : FULL_LEN;
    end else if (awxfer) begin
      addr_r  <= addr_r + axi_addr_t'(BURST_BYTES);
      awlen_r <= (bursts_left == burst_count_t'(1)) ? final_len : FULL_LEN;
    end
  end

  // Address beat held steady until the slave takes it
  aw_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_awvalid && !m_axi_awready |=>
      m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen));

endmodule

// ==== design/wdata_channel.sv ====
// Write data channel
`timescale 1ns/1ps

module wdata_channel
  import axi_burst_pkg::*, xfer_pkg::*;
(
  input  logic         aclk,
  input  logic         areset,
  input  logic         start,
  input  burst_count_t burst_count,
  input  burst_len_t   final_len,
  input  axi_strb_t    final_strb,
  input  logic         single_burst,
  input  logic         fifo_valid,
  input  axi_data_t    fifo_data,
  output logic         fifo_pop,
  output logic         m_axi_wvalid,
  input  logic         m_axi_wready,
  output axi_data_t    m_axi_wdata,
  output axi_strb_t    m_axi_wstrb,
  output logic         m_axi_wlast,
  output logic         first_beat_pulse
);

  localparam burst_len_t FULL_LEN = burst_len_t'(BURST_BEATS - 1);

  logic         running;
  logic         wxfer;
  logic         final_burst;
  logic         final_beat_xfer;
  logic         wfirst;
  logic         first_vis_d1;
  logic         first_vis_d2;
  burst_len_t   beats_left;
  burst_count_t bursts_left;

  ////////////////////////////////
  // Beat gating
  ////////////////////////////////

  // Nothing leaves the FIFO until the request is decoded
  assign m_axi_wvalid    = fifo_valid & running;
  assign m_axi_wdata     = fifo_data;
  assign wxfer           = m_axi_wvalid & m_axi_wready;
  assign fifo_pop        = wxfer;
  assign m_axi_wlast     = (beats_left == '0);
  assign final_burst     = (bursts_left == '0);
  assign final_beat_xfer = wxfer & m_axi_wlast & final_burst;
  // Partial strobe only on the very last beat
  assign m_axi_wstrb     = (m_axi_wlast & final_burst) ? final_strb : '1;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (final_beat_xfer) begin
      running <= 1'b0;
    end
  end

  ////////////////////////////////
  // Beat and burst counters
  ////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      beats_left  <= FULL_LEN;
      bursts_left <= '0;
    end else if (start) begin
      beats_left  <= single_burst ? final_len : FULL_LEN;
      bursts_left <= burst_count;
    end else if (wxfer) begin
      if (m_axi_wlast) begin
        // Next burst is the short one when only one remains
        beats_left  <= (bursts_left == burst_count_t'(1)) ? final_len : FULL_LEN;
        bursts_left <= bursts_left - 1'b1;
      end else begin
        beats_left <= beats_left - 1'b1;
      end
    end
  end

  ////////////////////////////////
  // First beat detection
  ////////////////////////////////

  // Set again after each wlast beat
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst           <= 1'b1;
      first_vis_d1     <= 1'b0;
      first_vis_d2     <= 1'b0;
      first_beat_pulse <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= m_axi_wlast;
      end
      first_vis_d1     <= m_axi_wvalid & wfirst;
      first_vis_d2     <= first_vis_d1;
      // One pulse per burst even if the first beat waits on wready
      first_beat_pulse <= first_vis_d1 & ~first_vis_d2;
    end
  end

  // A waiting beat stays on the bus unchanged until wready
  w_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_wvalid && !m_axi_wready |=>
      m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wlast) && $stable(m_axi_wstrb));

endmodule

// ==== design/stream_fifo.sv ====
// Stream data FIFO
`timescale 1ns/1ps
`include "write_master_config.svh"

module stream_fifo
  import axi_burst_pkg::*;
(
  input  logic      aclk,
  input  logic      areset,
  input  logic      wr_en,
  input  axi_data_t wr_data,
  output logic      full,
  input  logic      rd_en,
  output axi_data_t rd_data,
  output logic      rd_valid
);

  localparam int DEPTH = `WM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  axi_data_t          mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     count;

  // Storage, written on every accepted word
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  ////////////////////////////////
  // Pointers and fill level
  ////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the level unchanged
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head word shows as soon as it is stored
  assign rd_data  = mem[rd_ptr];
  assign rd_valid = (count != '0);
  assign full     = (count == (PTR_W + 1)'(DEPTH));

  // Upstream must respect full
  no_overflow: assert property (@(posedge aclk) disable iff (areset) !(wr_en && full));

  // Downstream pops only a presented word
  no_underflow: assert property (@(posedge aclk) disable iff (areset) !(rd_en && !rd_valid));

endmodule

// ==== design/xfer_setup.sv ====
// Request capture and decode
`timescale 1ns/1ps

module xfer_setup
  import axi_burst_pkg::*, xfer_pkg::*;
(
  input  logic         aclk,
  input  logic         ctrl_start,
  input  axi_addr_t    ctrl_addr_offset,
  input  xfer_size_u   ctrl_xfer_size_in_bytes,
  output logic         start,
  output axi_addr_t    addr_base,
  output burst_count_t burst_count,
  output burst_len_t   final_len,
  output axi_strb_t    final_strb,
  output logic         single_burst
);

  xfer_size_u  size_r;
  beat_count_t total_beats;
  axi_strb_t   strb_next;
  logic        start_d1;
  logic        start_d2;

  ////////////////////////////////
  // Request capture
  ////////////////////////////////

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      size_r    <= ctrl_xfer_size_in_bytes;
      // Start on a burst boundary so no burst crosses 4 KiB
      addr_base <= ctrl_addr_offset & ~axi_addr_t'(BURST_BYTES - 1);
    end
  end

  // Two stages so the decoded fields settle before start
  always_ff @(posedge aclk) begin
    start_d1 <= ctrl_start;
    start_d2 <= start_d1;
    start    <= start_d2;
  end

  ////////////////////////////////
  // Decode
  ////////////////////////////////

  // Whole words minus one, rounded up, from the raw byte count
  assign total_beats = beat_count_t'((size_r.bytes - 1'b1) >> LOG_DW_BYTES);

  // Last beat keeps bytes below the remainder
  always_comb begin
    for (int i = 0; i < DW_BYTES; i++) begin
      strb_next[i] = (size_r.split.remainder == '0) || (i < size_r.split.remainder);
    end
  end

  always_ff @(posedge aclk) begin
    // Upper bits count the full bursts, low bits size the last one
    burst_count  <= total_beats[BEAT_COUNT_WIDTH-1:LOG_BURST_BEATS];
    final_len    <= total_beats[LOG_BURST_BEATS-1:0];
    single_burst <= (total_beats[BEAT_COUNT_WIDTH-1:LOG_BURST_BEATS] == '0);
    final_strb   <= strb_next;
  end

endmodule

// ==== design/xfer_pkg.sv ====
// Transfer size decoding types
`include "write_master_config.svh"

package xfer_pkg;

  import axi_burst_pkg::*;

  localparam int LOG_DW_BYTES    = $clog2(DW_BYTES);
  localparam int LOG_BURST_BEATS = $clog2(BURST_BEATS);

  // Total beats minus one, and the bursts that follow the first
  localparam int BEAT_COUNT_WIDTH  = `WM_XFER_SIZE_WIDTH - LOG_DW_BYTES;
  localparam int BURST_COUNT_WIDTH = BEAT_COUNT_WIDTH - LOG_BURST_BEATS;

  typedef logic [BEAT_COUNT_WIDTH-1:0]  beat_count_t;
  typedef logic [BURST_COUNT_WIDTH-1:0] burst_count_t;

  // Byte count seen as whole words plus leftover bytes
  typedef struct packed {
    logic [BEAT_COUNT_WIDTH-1:0] words;
    logic [LOG_DW_BYTES-1:0]     remainder;
  } xfer_split_t;

  // Same request word, raw or split
  typedef union packed {
    logic [`WM_XFER_SIZE_WIDTH-1:0] bytes;
    xfer_split_t                    split;
  } xfer_size_u;

endpackage

// ==== design/axi_burst_pkg.sv ====
// AXI burst types
`include "write_master_config.svh"

package axi_burst_pkg;

  // Bytes per data beat
  localparam int DW_BYTES = `WM_DATA_WIDTH / 8;

  // Beats per full burst, bounded by both protocol limits
  localparam int BURST_BEATS =
    ((`WM_MAX_BURST_BYTES / DW_BYTES) < `WM_MAX_BURST_BEATS) ?
    (`WM_MAX_BURST_BYTES / DW_BYTES) : `WM_MAX_BURST_BEATS;

  // Address step between bursts
  localparam int BURST_BYTES = DW_BYTES * BURST_BEATS;

  typedef logic [`WM_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [`WM_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [DW_BYTES-1:0]       axi_strb_t;

  // Beats minus one, as carried on awlen
  typedef logic [7:0] burst_len_t;

  // Holds 0 up to the outstanding limit itself
  typedef logic [$clog2(`WM_MAX_OUTSTANDING + 1)-1:0] outstanding_t;

endpackage

// ==== design/write_master_config.svh ====
// Write master configuration
`ifndef WRITE_MASTER_CONFIG_SVH
`define WRITE_MASTER_CONFIG_SVH

// AXI address and data widths
`define WM_ADDR_WIDTH 32
`define WM_DATA_WIDTH 32

// Width of the request byte count
`define WM_XFER_SIZE_WIDTH 32

// Protocol burst limits
// 256 beats and 4 KiB per burst, whichever comes first
`define WM_MAX_BURST_BEATS 256
`define WM_MAX_BURST_BYTES 4096

// Address handshakes allowed to wait for a response
`define WM_MAX_OUTSTANDING 32

// Stream buffer depth in data words
`define WM_FIFO_DEPTH 32

`endif
